// ==== common/replay_config.svh ====
`ifndef REPLAY_CONFIG_SVH
`define REPLAY_CONFIG_SVH

// input word width, one transfer from the trace memory
`define RR_AXI_W 64

// every logging unit starts and ends on this bit alignment
`define RR_ALIGN 8
`define RR_ALIGN_LOG 3

// widest logging unit, header included
`define RR_UNIT_W 256

// a bit-length field, wide enough for 256
`define RR_OFFSET_W 9

// alignment slots per input word
`define RR_AXI_ALIGNED 8

// width of the total trace length input
`define RR_BITS_W 64

`endif

// ==== common/replay_pkg.sv ====
`include "replay_config.svh"

package replay_pkg;

    // one input word, the pieces cut from the shift buffer are the same size
    typedef logic [`RR_AXI_W-1:0] axi_word_t;

    // one assembled logging unit
    typedef logic [`RR_UNIT_W-1:0] unit_t;

    // unit length in bits, sits in the low bits of every unit header
    typedef logic [`RR_OFFSET_W-1:0] unit_len_t;

    // unit length counted in alignment slots
    // 256 bits -> 32 slots, so one bit wider than the slot count of a word
    typedef logic [`RR_OFFSET_W-`RR_ALIGN_LOG-1:0] aligned_len_t;

    // slot offset inside the lower buffer word
    typedef logic [$clog2(`RR_AXI_ALIGNED)-1:0] lo_off_t;

    // expected trace length in bits, padded to the alignment
    typedef logic [`RR_BITS_W-1:0] replay_bits_t;

endpackage

// ==== logic/replay_trace_parser.sv ====
`timescale 1ns/1ps

module replay_trace_parser
    import replay_pkg::*;
(
    input  logic         clk,
    input  logic         sync_rst_n,
    input  axi_word_t    in_data,
    input  logic         in_valid,
    output logic         in_ready,
    input  replay_bits_t replay_bits,
    output unit_t        out_unit,
    output logic         out_valid,
    input  logic         out_almost_full
);

    // HI <-> LO shift buffer link
    axi_word_t hi_data;
    logic hi_full;
    logic hi_lo_shift;

    // barrier outputs into the assembler
    logic piece_valid;
    axi_word_t piece_data;
    unit_len_t piece_len;

    hi_slot u_hi_slot (
        .clk             (clk),
        .sync_rst_n      (sync_rst_n),
        .in_data         (in_data),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .out_almost_full (out_almost_full),
        .replay_bits     (replay_bits),
        .hi_lo_shift     (hi_lo_shift),
        .hi_full         (hi_full),
        .hi_data         (hi_data)
    );

    // boundary finder and piece cutter
    lo_slot u_lo_slot (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .hi_data     (hi_data),
        .hi_full     (hi_full),
        .replay_bits (replay_bits),
        .hi_lo_shift (hi_lo_shift),
        .piece_valid (piece_valid),
        .piece_data  (piece_data),
        .piece_len   (piece_len)
    );

    unit_assembler u_unit_assembler (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .piece_valid (piece_valid),
        .piece_data  (piece_data),
        .piece_len   (piece_len),
        .out_unit    (out_unit),
        .out_valid   (out_valid)
    );

endmodule

// ==== logic/unit_assembler.sv ====
`timescale 1ns/1ps
`include "replay_config.svh"

module unit_assembler
    import replay_pkg::*;
(
    input  logic      clk,
    input  logic      sync_rst_n,
    input  logic      piece_valid,
    input  axi_word_t piece_data,
    input  unit_len_t piece_len,
    output unit_t     out_unit,
    output logic      out_valid
);

    localparam int NUM_W = `RR_UNIT_W / `RR_AXI_W;
    localparam int CNT_W = $clog2(NUM_W + 1);
    localparam int IDX_W = $clog2(NUM_W);
    localparam int AXI_LOG = $clog2(`RR_AXI_W);

    typedef enum logic [1:0] {ASM_WAIT_HEADER, ASM_WAIT_BODY, ASM_DONE} asm_state_e;

    asm_state_e asm_state;
    asm_state_e asm_state_next;
    axi_word_t unit_words [NUM_W];
    logic [CNT_W-1:0] word_cnt;
    unit_len_t unit_len;
    unit_len_t covered_len;
    logic first_fits;

    // bits held once the incoming body piece is stored
    assign covered_len = unit_len_t'(word_cnt + 1'b1) << AXI_LOG;
    // header piece already carries the whole unit
    assign first_fits = piece_len <= unit_len_t'(`RR_AXI_W);

    always_comb begin
        asm_state_next = asm_state;
        case (asm_state)
            ASM_WAIT_BODY: begin
                if (piece_valid && (unit_len <= covered_len)) begin
                    asm_state_next = ASM_DONE;
                end
            end
            ASM_WAIT_HEADER, ASM_DONE: begin
                // done has no stall, the sink keeps room via almost-full
                if (piece_valid) begin
                    asm_state_next = first_fits ? ASM_DONE : ASM_WAIT_BODY;
                end else begin
                    asm_state_next = ASM_WAIT_HEADER;
                end
            end
            default: begin
                asm_state_next = ASM_WAIT_HEADER;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            asm_state <= ASM_WAIT_HEADER;
            word_cnt <= '0;
            unit_len <= '0;
        end else begin
            asm_state <= asm_state_next;
            if (piece_valid) begin
                if (asm_state == ASM_WAIT_BODY) begin
                    word_cnt <= word_cnt + 1'b1;
                end else begin
                    // any piece outside wait-body opens a new unit
                    unit_len <= piece_len;
                    word_cnt <= CNT_W'(1);
                end
            end
        end
    end

    // unit payload, word 0 holds the header
    always_ff @(posedge clk) begin
        if (piece_valid) begin
            if (asm_state == ASM_WAIT_BODY) begin
                unit_words[word_cnt[IDX_W-1:0]] <= piece_data;
            end else begin
                unit_words[0] <= piece_data;
            end
        end
    end

    // bits above the unit length are leftovers
    always_comb begin
        for (int i = 0; i < NUM_W; i++) begin
            out_unit[i*`RR_AXI_W +: `RR_AXI_W] = unit_words[i];
        end
    end

    assign out_valid = (asm_state == ASM_DONE);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the replay trace parser regression with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_replay_trace_parser \
    -o sim_replay
./obj_dir/sim_replay > sim.log
cat sim.log

if grep -q "Regression passed" sim.log; then
    exit 0
fi
exit 1

// ==== shift_buffer/hi_slot.sv ====
`timescale 1ns/1ps
`include "replay_config.svh"

module hi_slot
    import replay_pkg::*;
(
    input  logic         clk,
    input  logic         sync_rst_n,
    input  axi_word_t    in_data,
    input  logic         in_valid,
    output logic         in_ready,
    input  logic         out_almost_full,
    input  replay_bits_t replay_bits,
    input  logic         hi_lo_shift,
    output logic         hi_full,
    output axi_word_t    hi_data
);

    localparam int AXI_LOG = $clog2(`RR_AXI_W);
    localparam int CNT_W = `RR_BITS_W - AXI_LOG;

    typedef enum logic {HI_EMPTY, HI_FULL} hi_state_e;

    hi_state_e hi_state;
    hi_state_e hi_state_next;
    logic accept;
    logic pad_load;
    logic pad_done;
    logic all_in;
    replay_bits_t bits_round;
    logic [CNT_W-1:0] word_total;
    logic [CNT_W-1:0] word_cnt;

    assign hi_full = (hi_state == HI_FULL);

    // take a word when HI is free now or frees up by the shift this cycle
    // the sink almost-full throttles only here, the rest of the pipe drains
    assign in_ready = !out_almost_full && (!hi_full || hi_lo_shift);
    assign accept = in_valid && in_ready;

    // number of words needed to carry replay_bits, rounded up
    assign bits_round = replay_bits + replay_bits_t'(`RR_AXI_W - 1);
    assign word_total = bits_round[`RR_BITS_W-1:AXI_LOG];
    assign all_in = (word_total != '0) && (word_cnt == word_total);

    // one zero word follows the last real word into HI
    // it gives the LO window something to reach into while the tail drains
    assign pad_load = hi_full && hi_lo_shift && all_in && !pad_done && !accept;

    always_comb begin
        hi_state_next = hi_state;
        case (hi_state)
            HI_EMPTY: begin
                if (accept) begin
                    hi_state_next = HI_FULL;
                end
            end
            HI_FULL: begin
                // shift without refill empties HI, shift with refill flows
                if (hi_lo_shift && !accept && !pad_load) begin
                    hi_state_next = HI_EMPTY;
                end
            end
            default: begin
                hi_state_next = HI_EMPTY;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            hi_state <= HI_EMPTY;
            word_cnt <= '0;
            pad_done <= 1'b0;
        end else begin
            hi_state <= hi_state_next;
            if (accept) begin
                word_cnt <= word_cnt + 1'b1;
            end
            if (pad_load) begin
                pad_done <= 1'b1;
            end
        end
    end

    // upper buffer word
    always_ff @(posedge clk) begin
        if (accept) begin
            hi_data <= in_data;
        end else if (pad_load) begin
            hi_data <= '0;
        end
    end

endmodule

// ==== shift_buffer/lo_slot.sv ====
`timescale 1ns/1ps
`include "replay_config.svh"

module lo_slot
    import replay_pkg::*;
(
    input  logic         clk,
    input  logic         sync_rst_n,
    input  axi_word_t    hi_data,
    input  logic         hi_full,
    input  replay_bits_t replay_bits,
    output logic         hi_lo_shift,
    output logic         piece_valid,
    output axi_word_t    piece_data,
    output unit_len_t    piece_len
);

    localparam int AL_W = $bits(aligned_len_t);
    localparam int EXH_W = AL_W + 1;
    localparam int PKT_W = `RR_BITS_W - `RR_ALIGN_LOG;

    typedef enum logic [1:0] {LO_EMPTY, LO_HEADER, LO_BODY} lo_state_e;

    lo_state_e lo_state;
    lo_state_e lo_state_next;
    axi_word_t lo_word;
    lo_off_t lo_off;
    logic [2*`RR_AXI_W-1:0] shift_buf;
    axi_word_t window;
    aligned_len_t lo_remain;
    aligned_len_t remain_reg;
    logic lo_empty;
    logic lo_out;
    logic lo_exhaust;
    logic lo_satisfied;
    logic replay_done;
    logic [PKT_W-1:0] pkt_total;
    logic [PKT_W-1:0] pkt_cnt;
    aligned_len_t pkt_add;

    assign lo_empty = (lo_state == LO_EMPTY);

    // one word window from the first valid LO slot reaching into HI
    assign shift_buf = {hi_data, lo_word};
    assign window = axi_word_t'(shift_buf >> (lo_off * `RR_ALIGN));

    // remaining slots of the unit under the window
    // the header state decodes the length field
    // the body state carries it over from the last cut
    always_comb begin
        case (lo_state)
            LO_HEADER: lo_remain = window[`RR_ALIGN_LOG +: AL_W];
            LO_BODY:   lo_remain = remain_reg;
            default:   lo_remain = '0;
        endcase
    end

    // the cut uses up the rest of LO
    assign lo_exhaust = (EXH_W'(lo_remain) + EXH_W'(lo_off)) >= EXH_W'(`RR_AXI_ALIGNED);
    // the cut finishes the unit
    assign lo_satisfied = lo_remain <= AL_W'(`RR_AXI_ALIGNED);

    // cut only with HI valid so the window holds continuous data
    assign lo_out = hi_full && !lo_empty && !replay_done;
    assign hi_lo_shift = hi_full && (lo_empty || (lo_out && lo_exhaust));

    always_comb begin
        lo_state_next = lo_state;
        case (lo_state)
            LO_EMPTY: begin
                if (hi_lo_shift) begin
                    lo_state_next = LO_HEADER;
                end
            end
            LO_HEADER, LO_BODY: begin
                if (hi_lo_shift) begin
                    // the unit goes on past this word in the body state
                    lo_state_next = lo_satisfied ? LO_HEADER : LO_BODY;
                end else if (lo_out && !lo_exhaust) begin
                    // the unit ended inside LO and the next header follows in place
                    lo_state_next = LO_HEADER;
                end
            end
            default: begin
                lo_state_next = LO_EMPTY;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            lo_state <= LO_EMPTY;
            lo_off <= '0;
            remain_reg <= '0;
        end else begin
            lo_state <= lo_state_next;
            if (lo_empty) begin
                lo_off <= '0;
            end else if (lo_out && lo_satisfied) begin
                // the next unit starts right behind the one that ended
                // after a shift the sum wraps into the new LO word
                lo_off <= lo_off + lo_off_t'(lo_remain);
            end
            // a full word went out and the unit carries on
            if (hi_lo_shift && !lo_satisfied) begin
                remain_reg <= lo_remain - AL_W'(`RR_AXI_ALIGNED);
            end
        end
    end

    // pkt_cnt plus the last cut held in pkt_add counts the aligned packets sent
    assign pkt_total = replay_bits[`RR_BITS_W-1:`RR_ALIGN_LOG];
    assign replay_done = (pkt_total == pkt_cnt + PKT_W'(pkt_add));

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            pkt_cnt <= '0;
            pkt_add <= '0;
        end else begin
            pkt_cnt <= pkt_cnt + PKT_W'(pkt_add);
            if (lo_out && lo_satisfied) begin
                pkt_add <= lo_remain;
            end else if (lo_out) begin
                pkt_add <= AL_W'(`RR_AXI_ALIGNED);
            end else begin
                pkt_add <= '0;
            end
        end
    end

    // lower buffer word
    always_ff @(posedge clk) begin
        if (hi_lo_shift) begin
            lo_word <= hi_data;
        end
    end

    // register barrier towards the assembler
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            piece_valid <= 1'b0;
        end else begin
            piece_valid <= lo_out;
        end
    end

    always_ff @(posedge clk) begin
        if (lo_out) begin
            piece_data <= window;
            piece_len <= {lo_remain, {`RR_ALIGN_LOG{1'b0}}};
        end
    end

endmodule

// ==== tests/tb_replay_checks.svh ====
`ifndef TB_REPLAY_CHECKS_SVH
`define TB_REPLAY_CHECKS_SVH

// linear congruential generator, state lives in the testbench module
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// random unit of the given length, header in the low bits, zeros above
function automatic unit_t make_unit(unit_len_t len);
    unit_t u;
    u = '0;
    for (int w = 0; w < `RR_UNIT_W / 32; w++) begin
        u[w*32 +: 32] = lcg_next();
    end
    for (int b = 0; b < `RR_UNIT_W; b++) begin
        if (b >= int'(len)) begin
            u[b] = 1'b0;
        end
    end
    u[`RR_OFFSET_W-1:0] = len;
    return u;
endfunction

// append one unit to the packed stream, no gap to the one before
task automatic pack_unit(unit_t u, unit_len_t len);
    int pos;
    while (stream_words.size() * `RR_AXI_W < bit_pos + int'(len)) begin
        stream_words.push_back('0);
    end
    for (int b = 0; b < int'(len); b++) begin
        pos = bit_pos + b;
        stream_words[pos / `RR_AXI_W][pos % `RR_AXI_W] = u[b];
    end
    bit_pos = bit_pos + int'(len);
    exp_units.push_back(u);
    exp_lens.push_back(len);
endtask

// only the low len bits of a unit carry data
task automatic check_unit(string name, unit_t got, unit_t exp, unit_len_t len);
    unit_t mask;
    mask = '0;
    for (int b = 0; b < int'(len); b++) begin
        mask[b] = 1'b1;
    end
    if ((got & mask) != (exp & mask)) begin
        $display("FAILED time=%0t signal=%s got=%h exp=%h", $time, name, got & mask,
                 exp & mask);
        errors++;
    end
endtask

task automatic check_len(string name, unit_len_t got, unit_len_t exp);
    if (got != exp) begin
        $display("FAILED time=%0t signal=%s got=%h exp=%h", $time, name, got, exp);
        errors++;
    end
endtask

`endif

// ==== tests/tb_replay_trace_parser.sv ====
`timescale 1ns/1ps
`include "replay_config.svh"

module tb_replay_trace_parser
    import replay_pkg::*;
;

    localparam int CLK_NS = 40;
    // number of units in each test
    localparam int N_SHORT = 24;
    localparam int N_CROSS = 30;
    localparam int N_FULL = 4;
    localparam int N_GAPS = 20;
    localparam int N_HOLD = 24;
    localparam int N_END = 12;
    // worst case words with every unit at 256 bits plus a few spare per test
    localparam int MAX_WORDS = (N_SHORT + N_CROSS + N_FULL + 3 + 2 * N_GAPS + N_HOLD + N_END)
                               * 4 + 16;
    localparam longint WATCHDOG_NS = longint'(CLK_NS) * 200 * MAX_WORDS;

    logic clk;
    logic sync_rst_n;
    axi_word_t in_data;
    logic in_valid;
    logic in_ready;
    replay_bits_t replay_bits;
    unit_t out_unit;
    logic out_valid;
    logic out_almost_full;

    logic [31:0] lcg_state;
    int errors;
    int tests_run;
    int tests_bad;
    int bit_pos;
    axi_word_t stream_words[$];
    unit_t exp_units[$];
    unit_len_t exp_lens[$];
    unit_t got_units[$];

    `include "tb_replay_checks.svh"

    replay_trace_parser DUT (
        .clk             (clk),
        .sync_rst_n      (sync_rst_n),
        .in_data         (in_data),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .replay_bits     (replay_bits),
        .out_unit        (out_unit),
        .out_valid       (out_valid),
        .out_almost_full (out_almost_full)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // sink model collects every unit that out_valid marks
    always @(negedge clk) begin
        if (sync_rst_n && out_valid) begin
            got_units.push_back(out_unit);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

    // fresh stream and expected lists
    task automatic clear_stream();
        stream_words.delete();
        exp_units.delete();
        exp_lens.delete();
        bit_pos = 0;
    endtask

    // reset the DUT and load the trace length for the next run
    task automatic start_run();
        @(negedge clk);
        in_valid = 1'b0;
        out_almost_full = 1'b0;
        replay_bits = replay_bits_t'(bit_pos);
        sync_rst_n = 1'b0;
        repeat (3) @(negedge clk);
        sync_rst_n = 1'b1;
        got_units.delete();
    endtask

    // one word per falling edge until the DUT has taken them all
    task automatic drive_words(bit gaps);
        int idx;
        bit taken;
        idx = 0;
        while (idx < stream_words.size()) begin
            @(negedge clk);
            in_valid = gaps ? (lcg_next() % 4 != 0) : 1'b1;
            in_data = stream_words[idx];
            #(CLK_NS / 4);
            if (out_almost_full && in_ready) begin
                $display("in_ready high while out_almost_full is held at %0t", $time);
                errors++;
            end
            taken = in_valid && in_ready;
            @(posedge clk);
            if (taken) begin
                idx++;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_units();
        int cycles;
        int limit;
        cycles = 0;
        limit = 200 * stream_words.size() + 100;
        while (got_units.size() < exp_units.size() && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (got_units.size() < exp_units.size()) begin
            $display("units missing after %0d cycles of waiting", limit);
            errors++;
        end
    endtask

    task automatic check_results();
        int n;
        if (got_units.size() != exp_units.size()) begin
            $display("unit count wrong: got %0d, expected %0d", got_units.size(),
                     exp_units.size());
            errors++;
        end
        n = (got_units.size() < exp_units.size()) ? got_units.size() : exp_units.size();
        for (int i = 0; i < n; i++) begin
            check_len("out_unit.len", got_units[i][`RR_OFFSET_W-1:0], exp_lens[i]);
            check_unit("out_unit", got_units[i], exp_units[i], exp_lens[i]);
        end
    endtask

    task automatic run_stream(bit gaps);
        start_run();
        drive_words(gaps);
        wait_units();
        check_results();
    endtask

    task automatic report_test(string name, int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    // random aligned length within [lo, hi] bits
    function automatic unit_len_t pick_len(int lo, int hi);
        return unit_len_t'(lo + 8 * (lcg_next() % ((hi - lo) / 8 + 1)));
    endfunction

    task automatic test_short_units();
        int e;
        unit_len_t len;
        e = errors;
        clear_stream();
        for (int i = 0; i < N_SHORT; i++) begin
            len = pick_len(16, 56);
            pack_unit(make_unit(len), len);
        end
        run_stream(1'b0);
        report_test("short_units", e);
    endtask

    task automatic test_cross_words();
        int e;
        unit_len_t len;
        e = errors;
        clear_stream();
        for (int i = 0; i < N_CROSS; i++) begin
            len = pick_len(16, 256);
            pack_unit(make_unit(len), len);
        end
        run_stream(1'b0);
        report_test("cross_words", e);
    endtask

    task automatic test_full_units();
        int e;
        e = errors;
        clear_stream();
        // small leading units shift the full ones off the word grid
        pack_unit(make_unit(9'd24), 9'd24);
        pack_unit(make_unit(9'd256), 9'd256);
        pack_unit(make_unit(9'd256), 9'd256);
        pack_unit(make_unit(9'd40), 9'd40);
        pack_unit(make_unit(9'd256), 9'd256);
        pack_unit(make_unit(9'd256), 9'd256);
        run_stream(1'b0);
        report_test("full_units", e);
    endtask

    task automatic test_input_gaps();
        int e;
        unit_len_t len;
        e = errors;
        clear_stream();
        for (int i = 0; i < N_GAPS; i++) begin
            len = pick_len(16, 256);
            pack_unit(make_unit(len), len);
        end
        // the stream runs once without and once with input gaps
        run_stream(1'b0);
        run_stream(1'b1);
        report_test("input_gaps", e);
    endtask

    task automatic test_back_pressure();
        int e;
        int base;
        unit_len_t len;
        e = errors;
        clear_stream();
        // long units keep the drained backlog within three
        for (int i = 0; i < N_HOLD; i++) begin
            len = pick_len(128, 256);
            pack_unit(make_unit(len), len);
        end
        start_run();
        fork
            drive_words(1'b0);
            begin
                repeat (8) @(negedge clk);
                out_almost_full = 1'b1;
                // count once the sink has taken the unit of this edge
                #(CLK_NS / 4);
                base = got_units.size();
                repeat (40) @(negedge clk);
                out_almost_full = 1'b0;
                #(CLK_NS / 4);
                if (got_units.size() - base > 3) begin
                    $display("%0d units arrived during almost-full, at most 3 allowed",
                             got_units.size() - base);
                    errors++;
                end
            end
        join
        wait_units();
        check_results();
        report_test("back_pressure", e);
    endtask

    task automatic test_end_of_trace();
        int e;
        int last;
        unit_len_t len;
        e = errors;
        clear_stream();
        for (int i = 0; i < N_END; i++) begin
            len = pick_len(16, 256);
            pack_unit(make_unit(len), len);
        end
        run_stream(1'b0);
        last = exp_units.size() - 1;
        if (got_units.size() == exp_units.size()) begin
            check_unit("out_unit.last", got_units[last], exp_units[last], exp_lens[last]);
        end
        // nothing more may come out once the trace is drained
        repeat (50) begin
            @(negedge clk);
            if (out_valid) begin
                $display("out_valid high after the last unit at %0t", $time);
                errors++;
            end
        end
        report_test("end_of_trace", e);
    endtask

    initial begin
        clk = 1'b0;
        sync_rst_n = 1'b0;
        in_data = '0;
        in_valid = 1'b0;
        replay_bits = '0;
        out_almost_full = 1'b0;
        lcg_state = 32'h9b6c;
        errors = 0;
        tests_run = 0;
        tests_bad = 0;
        bit_pos = 0;

        test_short_units();
        test_cross_words();
        test_full_units();
        test_input_gaps();
        test_back_pressure();
        test_end_of_trace();

        $display("tests run %0d, tests with errors %0d, total errors %0d", tests_run,
                 tests_bad, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+common
+incdir+tests
common/replay_pkg.sv
shift_buffer/hi_slot.sv
shift_buffer/lo_slot.sv
logic/unit_assembler.sv
logic/replay_trace_parser.sv
tests/tb_replay_trace_parser.sv
